//--- compressor_4to2.sv
module compressor_4to2 (
    input  logic x1,
    input  logic x2,
    input  logic x3,
    input  logic x4,
    input  logic cin,
    output logic sum,
    output logic carry,
    output logic cout
);

    logic s3;   // partial sum of x1..x3

    // first full adder, cout is independent of cin
    assign s3   = x1 ^ x2 ^ x3;
    assign cout = (x1 & x2) | (x2 & x3) | (x1 & x3);

    // second full adder
    assign sum   = s3 ^ x4 ^ cin;
    assign carry = (s3 & x4) | (x4 & cin) | (s3 & cin);

endmodule

//--- csa_row_4to2.sv
module csa_row_4to2 #(
    parameter int WIDTH = dadda_pkg::PROD_W
) (
    input  logic [WIDTH-1:0] op0,
    input  logic [WIDTH-1:0] op1,
    input  logic [WIDTH-1:0] op2,
    input  logic [WIDTH-1:0] op3,
    output logic [WIDTH-1:0] sum,
    output logic [WIDTH-1:0] carry
);

    logic [WIDTH-1:0] cin_vec;   // cout of the cell below
    logic [WIDTH-1:0] cout_vec;
    logic [WIDTH-1:0] cell_carry;

    assign cin_vec = {cout_vec[WIDTH-2:0], 1'b0};

    for (genvar i = 0; i < WIDTH; i++) begin : g_cell
        compressor_4to2 u_cell (
            .x1    (op0[i]),
            .x2    (op1[i]),
            .x3    (op2[i]),
            .x4    (op3[i]),
            .cin   (cin_vec[i]),
            .sum   (sum[i]),
            .carry (cell_carry[i]),
            .cout  (cout_vec[i])
        );
    end

    // carries weigh one place up, top bit falls off
    assign carry = {cell_carry[WIDTH-2:0], 1'b0};

endmodule

//--- dadda_mult.f
dadda_pkg.sv
compressor_4to2.sv
csa_row_4to2.sv
pipe_stage.sv
pp_reduce_front.sv
pp_reduce_back.sv
prefix_adder.sv
dadda_mult.sv
dadda_mult_chk.sv
tb_dadda_mult.sv

//--- dadda_mult.sv
module dadda_mult (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  dadda_pkg::operand_pair_t in_data,
    output logic                     out_valid,
    input  logic                     out_ready,
    output dadda_pkg::prod_t         out_data
);

    import dadda_pkg::*;

    wire [N_STAGES-1:0] vld;   // valid out of each stage
    wire [N_STAGES-1:0] rdy;   // ready into each stage

    csa8_t rows_comb, rows_q;
    csa2_t pair_comb, pair_q;
    prod_t total;

    // stage 1: partial products and 16 -> 8
    pp_reduce_front u_front (.operands(in_data), .rows(rows_comb));

    pipe_stage #(.payload_t(csa8_t)) u_stage1 (
        .clk, .rst_n,
        .up_valid   (in_valid),
        .up_ready   (rdy[0]),
        .up_data    (rows_comb),
        .down_valid (vld[0]),
        .down_ready (rdy[1]),
        .down_data  (rows_q)
    );

    // stage 2: 8 -> 4 -> 2
    pp_reduce_back u_back (.rows(rows_q), .pair(pair_comb));

    pipe_stage #(.payload_t(csa2_t)) u_stage2 (
        .clk, .rst_n,
        .up_valid   (vld[0]),
        .up_ready   (rdy[1]),
        .up_data    (pair_comb),
        .down_valid (vld[1]),
        .down_ready (rdy[2]),
        .down_data  (pair_q)
    );

    // stage 3: carry-propagate add
    prefix_adder u_adder (.pair(pair_q), .total(total));

    pipe_stage #(.payload_t(prod_t)) u_stage3 (
        .clk, .rst_n,
        .up_valid   (vld[1]),
        .up_ready   (rdy[2]),
        .up_data    (total),
        .down_valid (vld[N_STAGES-1]),
        .down_ready (out_ready),
        .down_data  (out_data)
    );

    assign in_ready  = rdy[0];
    assign out_valid = vld[N_STAGES-1];

endmodule

//--- dadda_mult_chk.sv
module dadda_mult_chk (
    input logic             clk,
    input logic             rst_n,
    input logic             out_valid,
    input logic             out_ready,
    input dadda_pkg::prod_t out_data
);

    timeunit 1ns;
    timeprecision 1ps;

    // a stalled output keeps its item
    property p_hold_on_stall;
        @(posedge clk) disable iff (!rst_n)
            out_valid && !out_ready |=> out_valid && $stable(out_data);
    endproperty

    // sampled mid-cycle, after the async reset has acted
    property p_idle_in_reset;
        @(negedge clk) !rst_n |-> !out_valid;
    endproperty

    property p_known_data;
        @(posedge clk) disable iff (!rst_n)
            out_valid |-> !$isunknown(out_data);
    endproperty

    a_hold_on_stall: assert property (p_hold_on_stall)
        else $error("out_data changed or out_valid dropped during a stall");
    a_idle_in_reset: assert property (p_idle_in_reset)
        else $error("out_valid high while in reset");
    a_known_data: assert property (p_known_data)
        else $error("out_data has unknown bits while out_valid is high");

endmodule

bind dadda_mult dadda_mult_chk u_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
);

//--- dadda_pkg.sv
package dadda_pkg;

    localparam int OP_W     = 16;
    localparam int PROD_W   = 2 * OP_W;   // full product, also csa row width
    localparam int N_STAGES = 3;          // register stages from input to output

    typedef logic [OP_W-1:0]   operand_t;
    typedef logic [PROD_W-1:0] prod_t;

    // input payload
    typedef struct packed {
        operand_t a;
        operand_t b;
    } operand_pair_t;

    // payload after the first compression level
    typedef struct packed {
        prod_t [7:0] row;
    } csa8_t;

    // redundant sum ready for the final adder
    typedef struct packed {
        prod_t sum;
        prod_t carry;
    } csa2_t;

endpackage

//--- pipe_stage.sv
module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     up_valid,
    output logic     up_ready,
    input  payload_t up_data,
    output logic     down_valid,
    input  logic     down_ready,
    output payload_t down_data
);

    logic load;

    // free slot, or the held item leaves this cycle
    assign up_ready = !down_valid || down_ready;
    assign load     = up_valid && up_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            down_valid <= 1'b0;
        end else if (load) begin
            down_valid <= 1'b1;
        end else if (down_ready) begin
            down_valid <= 1'b0;   // drained, nothing new
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            down_data <= up_data;
        end
    end

endmodule

//--- pp_reduce_back.sv
module pp_reduce_back (
    input  dadda_pkg::csa8_t rows,
    output dadda_pkg::csa2_t pair
);

    import dadda_pkg::*;

    prod_t sum_lo, carry_lo;   // from rows 0..3
    prod_t sum_hi, carry_hi;   // from rows 4..7
    prod_t sum_fin, carry_fin;

    // 8 -> 4
    csa_row_4to2 #(.WIDTH(PROD_W)) u_row_lo (
        .op0   (rows.row[0]),
        .op1   (rows.row[1]),
        .op2   (rows.row[2]),
        .op3   (rows.row[3]),
        .sum   (sum_lo),
        .carry (carry_lo)
    );

    csa_row_4to2 #(.WIDTH(PROD_W)) u_row_hi (
        .op0   (rows.row[4]),
        .op1   (rows.row[5]),
        .op2   (rows.row[6]),
        .op3   (rows.row[7]),
        .sum   (sum_hi),
        .carry (carry_hi)
    );

    // 4 -> 2
    csa_row_4to2 #(.WIDTH(PROD_W)) u_row_fin (
        .op0   (sum_lo),
        .op1   (carry_lo),
        .op2   (sum_hi),
        .op3   (carry_hi),
        .sum   (sum_fin),
        .carry (carry_fin)
    );

    assign pair = '{sum: sum_fin, carry: carry_fin};

endmodule

//--- pp_reduce_front.sv
module pp_reduce_front (
    input  dadda_pkg::operand_pair_t operands,
    output dadda_pkg::csa8_t         rows
);

    import dadda_pkg::*;

    prod_t pp [OP_W];        // shifted partial products
    prod_t grp_sum [4];
    prod_t grp_carry [4];

    // row i is a gated by b[i], weighted by 2^i
    for (genvar i = 0; i < OP_W; i++) begin : g_pp
        assign pp[i] = prod_t'(operands.a & {OP_W{operands.b[i]}}) << i;
    end

    // four consecutive rows per compressor row
    for (genvar g = 0; g < 4; g++) begin : g_row
        csa_row_4to2 #(
            .WIDTH (PROD_W)
        ) u_row (
            .op0   (pp[4*g]),
            .op1   (pp[4*g+1]),
            .op2   (pp[4*g+2]),
            .op3   (pp[4*g+3]),
            .sum   (grp_sum[g]),
            .carry (grp_carry[g])
        );
    end

    always_comb begin
        for (int g = 0; g < 4; g++) begin
            rows.row[2*g]   = grp_sum[g];
            rows.row[2*g+1] = grp_carry[g];
        end
    end

endmodule

//--- prefix_adder.sv
module prefix_adder (
    input  dadda_pkg::csa2_t pair,
    output dadda_pkg::prod_t total
);

    import dadda_pkg::*;

    // level 0 holds the per-bit terms, the last level the group terms
    prod_t gen  [$clog2(PROD_W)+1];
    prod_t prop [$clog2(PROD_W)+1];
    prod_t half_sum;
    prod_t carries;

    assign half_sum = pair.sum ^ pair.carry;
    assign gen[0]   = pair.sum & pair.carry;
    assign prop[0]  = half_sum;

    // kogge-stone, span doubles every level
    for (genvar lvl = 0; lvl < $clog2(PROD_W); lvl++) begin : g_lvl
        for (genvar i = 0; i < PROD_W; i++) begin : g_bit
            if (i >= (1 << lvl)) begin : g_merge
                assign gen[lvl+1][i] = gen[lvl][i]
                                     | (prop[lvl][i] & gen[lvl][i - (1 << lvl)]);
                assign prop[lvl+1][i] = prop[lvl][i] & prop[lvl][i - (1 << lvl)];
            end else begin : g_pass
                assign gen[lvl+1][i]  = gen[lvl][i];   // prefix already complete
                assign prop[lvl+1][i] = prop[lvl][i];
            end
        end
    end

    // carry into bit i is the group generate of bits i-1..0
    assign carries = {gen[$clog2(PROD_W)][PROD_W-2:0], 1'b0};

    // product fits, carry out is dropped
    assign total = half_sum ^ carries;

endmodule

//--- tb_dadda_mult.sv
module tb_dadda_mult;

    timeunit 1ns;
    timeprecision 1ps;

    import dadda_pkg::*;

    localparam int          N_TABLE    = 12;
    localparam int          N_RANDOM   = 200;
    localparam int          MAX_CYCLES = 4 * (N_TABLE + N_RANDOM) + 50;
    localparam logic [31:0] SEED       = 32'hd3de_ad59;

    typedef struct packed {
        operand_t a;
        operand_t b;
        prod_t    p;
    } vector_t;

    localparam vector_t VECTORS [N_TABLE] = '{
        '{16'h0000, 16'h0000, 32'h0000_0000},
        '{16'hffff, 16'hffff, 32'hfffe_0001},
        '{16'h0001, 16'h1234, 32'h0000_1234},
        '{16'h1234, 16'h0001, 32'h0000_1234},
        '{16'h0100, 16'h0100, 32'h0001_0000},
        '{16'h8000, 16'h8000, 32'h4000_0000},
        '{16'haaaa, 16'h5555, 32'h38e3_1c72},
        '{16'haaaa, 16'haaaa, 32'h71c6_38e4},
        '{16'h5555, 16'h5555, 32'h1c71_8e39},
        '{16'hffff, 16'h0001, 32'h0000_ffff},
        '{16'h00ff, 16'hff00, 32'h00fe_0100},
        '{16'h1234, 16'h5678, 32'h0626_0060}
    };

    logic          clk;
    logic          rst_n;
    logic          in_valid;
    logic          in_ready;
    operand_pair_t in_data;
    logic          out_valid;
    logic          out_ready;
    prod_t         out_data;

    int          cycle      = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    int          in_count   = 0;
    int          out_count  = 0;
    bit          check_latency = 1'b0;
    bit          random_sink   = 1'b0;
    logic [31:0] rnd_state;
    prod_t       exp_q [$];    // expected products in arrival order
    int          cyc_q [$];    // accept cycle of each pending input

    dadda_mult UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle++;
        if (cycle >= MAX_CYCLES) begin
            $display("ERROR: run timed out after %0d cycles", cycle);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s expected %h, got %h",
                     $time, name, expected, actual);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    // inputs move 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
        if (random_sink) begin
            rnd_state = xorshift32(rnd_state);
            out_ready = |rnd_state[1:0];   // ready about 3 cycles in 4
        end
    endtask

    task automatic send_pair(input operand_t a, input operand_t b, input prod_t expected);
        bit accepted;
        in_data  = '{a: a, b: b};
        in_valid = 1'b1;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = in_ready;
            if (check_latency)
                check_value("in_ready", 1, in_ready);   // free sink never stalls the input
            if (accepted) begin
                exp_q.push_back(expected);
                cyc_q.push_back(cycle);
                in_count++;
            end
            next_cycle();
        end
    endtask

    task automatic drain();
        in_valid = 1'b0;
        while (exp_q.size() != 0) begin
            next_cycle();
        end
        check_value("output count", in_count, out_count);
    endtask

    task automatic report_test(input string name, input int fails_before);
        if (fail_count == fails_before)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d check(s) failed", name, fail_count - fails_before);
    endtask

    // scoreboard samples mid-cycle where handshake signals are settled
    always @(negedge clk) begin : monitor
        prod_t expected;
        int    sent_at;
        if (rst_n && out_valid && out_ready) begin
            out_count++;
            if (exp_q.size() == 0) begin
                $display("ERROR at %0t ns: output transfer with no pending input", $time);
                fail_count++;
            end else begin
                expected = exp_q.pop_front();
                sent_at  = cyc_q.pop_front();
                check_value("out_data", expected, out_data);
                if (check_latency)
                    check_value("latency", N_STAGES, cycle - sent_at);
            end
        end
    end

    initial begin
        int       fails_before;
        operand_t a;
        operand_t b;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b1;
        rnd_state = SEED;

        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        fails_before = fail_count;
        @(negedge clk);
        check_value("out_valid", 0, out_valid);
        check_value("in_ready", 1, in_ready);
        next_cycle();
        report_test("reset", fails_before);

        // back to back into a free sink with fixed latency
        fails_before  = fail_count;
        check_latency = 1'b1;
        in_count      = 0;
        out_count     = 0;
        for (int i = 0; i < N_TABLE; i++) begin
            send_pair(VECTORS[i].a, VECTORS[i].b, VECTORS[i].p);
        end
        drain();
        check_latency = 1'b0;
        report_test("table", fails_before);

        fails_before = fail_count;
        random_sink  = 1'b1;
        in_count     = 0;
        out_count    = 0;
        for (int i = 0; i < N_RANDOM; i++) begin
            rnd_state = xorshift32(rnd_state);
            a = rnd_state[15:0];
            b = rnd_state[31:16];
            send_pair(a, b, prod_t'(a) * prod_t'(b));
        end
        drain();
        random_sink = 1'b0;
        out_ready   = 1'b1;
        report_test("random with back-pressure", fails_before);

        $display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
